//--- logic/sme_pkg.sv
`default_nettype none

package sme_pkg;

  // Data path geometry
  // ----------------------------------------------------------

  localparam int XLEN     = 32;            // Bits per word and per share
  localparam int RF_DEPTH = 16;            // Registers per share file
  localparam int ADDR_W   = 4;             // Register address width

  // Operation encoding
  // ----------------------------------------------------------

  // Boolean masked ops only
  typedef enum logic [2:0] {
    OP_XOR    = 3'd0,                      // Share-wise xor of rs1 and rs2
    OP_AND    = 3'd1,                      // ISW masked and
    OP_NOT    = 3'd2,                      // Invert share 0 of rs1
    OP_MASK   = 3'd3,                      // Split plain share 0 into d shares
    OP_UNMASK = 3'd4,                      // Collapse d shares into share 0
    OP_REMASK = 3'd5                       // Refresh higher shares of rs1
  } sme_op_e;

  // Random source seeding
  // ----------------------------------------------------------

  // Even base so that base plus an odd offset is never zero
  localparam logic [XLEN-1:0] RNG_SEED_BASE = 32'h5ee0_1c2a;

  // Odd step, lane i gets base + step*(2i+1)
  localparam logic [XLEN-1:0] RNG_LANE_STEP = 32'h9e37_79b9;

endpackage

`default_nettype wire

//--- logic/sme_rng.sv
`timescale 1ns/1ps
`default_nettype none

module sme_rng #(
  parameter int SMAX = 3                                   // Max hardware shares
) (
  input  wire                                           g_clk,    // Global clock
  input  wire                                           reset_i,  // Sync reset
  output logic [SMAX*(SMAX-1)/2-1:0][sme_pkg::XLEN-1:0] rng_o     // Guard words
);

  import sme_pkg::*;

  localparam int NRAND = SMAX*(SMAX-1)/2;                  // Words per cycle

  // Generator state
  // ----------------------------------------------------------

  logic [NRAND-1:0][XLEN-1:0] lane_q;                      // One xorshift per lane

  // Marsaglia xorshift32 step, never maps nonzero to zero
  function automatic logic [XLEN-1:0] xs32_step(input logic [XLEN-1:0] x);
    logic [XLEN-1:0] t;
    t = x ^ (x << 13);
    t = t ^ (t >> 17);
    t = t ^ (t << 5);
    return t;
  endfunction

  always_ff @(posedge g_clk) begin
    if (reset_i) begin
      for (int i = 0; i < NRAND; i++) begin
        // Odd seed per lane
        lane_q[i] <= RNG_SEED_BASE + RNG_LANE_STEP * XLEN'(2*i+1);
      end
    end else begin
      for (int i = 0; i < NRAND; i++) begin
        lane_q[i] <= xs32_step(lane_q[i]);                 // Free running
      end
    end
  end

  assign rng_o = lane_q;                                   // Fresh every cycle

  // Checks
  // ----------------------------------------------------------

  // A zero lane would lock up and leak unmasked data from then on
  for (genvar g = 0; g < NRAND; g++) begin : g_lane_chk
    a_lane_nonzero: assert property (
      @(posedge g_clk) disable iff (reset_i)
      lane_q[g] != '0
    );
  end

endmodule

`default_nettype wire

//--- logic/sme_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module sme_regfile (
  input  wire                       g_clk,        // Global clock
  input  wire                       reset_i,      // Sync reset
  input  wire  [sme_pkg::ADDR_W-1:0] rs1_addr_i,  // Read port 1 address
  output logic [sme_pkg::XLEN-1:0]   rs1_rdata_o, // Read port 1 data
  input  wire  [sme_pkg::ADDR_W-1:0] rs2_addr_i,  // Read port 2 address
  output logic [sme_pkg::XLEN-1:0]   rs2_rdata_o, // Read port 2 data
  input  wire                       wen_i,        // Write strobe
  input  wire  [sme_pkg::ADDR_W-1:0] waddr_i,     // Write address
  input  wire  [sme_pkg::XLEN-1:0]   wdata_i      // Write data
);

  import sme_pkg::*;

  // Storage
  // ----------------------------------------------------------

  // One share of every architectural register
  logic [XLEN-1:0] mem_q [RF_DEPTH];

  // Cleared at reset so stale shares never recombine with new ones
  always_ff @(posedge g_clk) begin
    if (reset_i) begin
      for (int i = 0; i < RF_DEPTH; i++) begin
        mem_q[i] <= '0;                             // All shares zero
      end
    end else if (wen_i) begin
      mem_q[waddr_i] <= wdata_i;                    // Bank or ALU write
    end
  end

  // Read ports
  // ----------------------------------------------------------

  // Combinational, operands valid in the issue cycle
  assign rs1_rdata_o = mem_q[rs1_addr_i];           // ALU rs1 share
  assign rs2_rdata_o = mem_q[rs2_addr_i];           // ALU rs2 share and bank read

endmodule

`default_nettype wire

//--- logic/sme_alu.sv
`timescale 1ns/1ps
`default_nettype none

module sme_alu #(
  parameter int SMAX = 3                                      // Max hardware shares
) (
  input  wire                                           g_clk,      // Global clock
  input  wire                                           reset_i,    // Sync reset
  input  wire                                           flush_i,    // Kill in-flight ops
  input  wire  [2:0]                                    smectl_d_i, // Shares in use
  input  wire                                           valid_i,    // Issue strobe
  input  wire  sme_pkg::sme_op_e                        op_i,       // Operation
  input  wire  [sme_pkg::ADDR_W-1:0]                    rd_addr_i,  // Destination
  input  wire  [SMAX-1:0][sme_pkg::XLEN-1:0]            rs1_i,      // rs1 shares
  input  wire  [SMAX-1:0][sme_pkg::XLEN-1:0]            rs2_i,      // rs2 shares
  input  wire  [SMAX*(SMAX-1)/2-1:0][sme_pkg::XLEN-1:0] rng_i,      // Guard randomness
  output logic                                          done_o,     // Result strobe
  output logic [sme_pkg::ADDR_W-1:0]                    rd_addr_o,  // Result address
  output logic [SMAX-1:0][sme_pkg::XLEN-1:0]            rd_o        // Result shares
);

  import sme_pkg::*;

  localparam int NRAND = SMAX*(SMAX-1)/2;                     // One per share pair

  // Stage 1 partial products
  // ----------------------------------------------------------

  logic [SMAX-1:0][XLEN-1:0]  s1_part_d;                      // Per-share term
  logic [NRAND-1:0][XLEN-1:0] s1_lo_d;                        // Pair term for lower share
  logic [NRAND-1:0][XLEN-1:0] s1_hi_d;                        // Pair term for upper share

  always_comb begin
    int              k;                                       // Pair index
    logic [XLEN-1:0] acc;                                     // Share 0 fold
    k         = 0;
    acc       = '0;
    s1_part_d = '0;
    s1_lo_d   = '0;
    s1_hi_d   = '0;
    case (op_i)
      OP_XOR: begin
        s1_part_d = rs1_i ^ rs2_i;                            // Linear, share-wise
      end
      OP_NOT: begin
        s1_part_d    = rs1_i;
        s1_part_d[0] = ~rs1_i[0];                             // One inversion suffices
      end
      OP_AND: begin
        for (int i = 0; i < SMAX; i++) begin
          s1_part_d[i] = rs1_i[i] & rs2_i[i];                 // Diagonal terms
        end
        for (int i = 0; i < SMAX; i++) begin
          for (int j = i + 1; j < SMAX; j++) begin
            if (j < smectl_d_i) begin                         // Pair fully in use
              s1_lo_d[k] = rng_i[k];
              // Blind first cross product before adding the second
              s1_hi_d[k] = (rng_i[k] ^ (rs1_i[i] & rs2_i[j])) ^ (rs1_i[j] & rs2_i[i]);
            end
            k = k + 1;
          end
        end
      end
      OP_MASK: begin
        acc = rs1_i[0];                                       // Plain value from core
        for (int i = 1; i < SMAX; i++) begin
          if (i < smectl_d_i) begin
            s1_part_d[i] = rng_i[i-1];                        // Random becomes a share
            acc          = acc ^ rng_i[i-1];
          end
        end
        s1_part_d[0] = acc;
      end
      OP_UNMASK: begin
        for (int i = 0; i < SMAX; i++) begin
          if (i < smectl_d_i) begin
            acc = acc ^ rs1_i[i];                             // Recombine in-use shares
          end
        end
        s1_part_d[0] = acc;                                   // Higher shares stay zero
      end
      OP_REMASK: begin
        acc = rs1_i[0];
        for (int i = 1; i < SMAX; i++) begin
          if (i < smectl_d_i) begin
            s1_part_d[i] = rs1_i[i] ^ rng_i[i-1];             // Fresh mask in
            acc          = acc ^ rng_i[i-1];                  // Same mask folded out
          end
        end
        s1_part_d[0] = acc;
      end
      default: begin
      end
    endcase
  end

  logic                       s1_valid_q;                     // Stage 1 occupied
  sme_op_e                    s1_op_q;
  logic [2:0]                 s1_d_q;                         // Share count of this op
  logic [ADDR_W-1:0]          s1_rd_q;
  logic [SMAX-1:0][XLEN-1:0]  s1_part_q;
  logic [NRAND-1:0][XLEN-1:0] s1_lo_q;
  logic [NRAND-1:0][XLEN-1:0] s1_hi_q;

  always_ff @(posedge g_clk) begin
    if (reset_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= valid_i && !flush_i;                      // Flush kills issue too
    end
  end

  always_ff @(posedge g_clk) begin
    if (valid_i) begin                                        // Payload only on issue
      s1_op_q   <= op_i;
      s1_d_q    <= smectl_d_i;
      s1_rd_q   <= rd_addr_i;
      s1_part_q <= s1_part_d;
      s1_lo_q   <= s1_lo_d;
      s1_hi_q   <= s1_hi_d;
    end
  end

  // Stage 2 compression
  // ----------------------------------------------------------

  logic [SMAX-1:0][XLEN-1:0] s2_rd_d;
  logic                      s1_fire;                         // Survives to done

  assign s1_fire = s1_valid_q && !flush_i;

  always_comb begin
    int k;
    k       = 0;
    s2_rd_d = s1_part_q;
    if (s1_op_q == OP_AND) begin
      for (int i = 0; i < SMAX; i++) begin
        for (int j = i + 1; j < SMAX; j++) begin
          s2_rd_d[i] = s2_rd_d[i] ^ s1_lo_q[k];               // r_ij to share i
          s2_rd_d[j] = s2_rd_d[j] ^ s1_hi_q[k];               // Blinded cross to share j
          k = k + 1;
        end
      end
    end
    for (int i = 0; i < SMAX; i++) begin
      if (i >= s1_d_q) begin
        s2_rd_d[i] = '0;                                      // Unused shares cleared
      end
    end
  end

  always_ff @(posedge g_clk) begin
    if (reset_i) begin
      done_o    <= 1'b0;
      rd_addr_o <= '0;
      rd_o      <= '0;                                        // Result reads 0 after reset
    end else begin
      done_o <= s1_fire;
      if (s1_fire) begin
        rd_addr_o <= s1_rd_q;
        rd_o      <= s2_rd_d;
      end
    end
  end

  // Checks
  // ----------------------------------------------------------

  a_share_count: assert property (
    @(posedge g_clk) disable iff (reset_i)
    valid_i |-> (smectl_d_i >= 3'd2 && int'(smectl_d_i) <= SMAX)
  );

  // Both stages must drop their op on flush
  a_flush_kill: assert property (
    @(posedge g_clk) disable iff (reset_i)
    ($past(flush_i) || $past(flush_i, 2)) |-> !done_o
  );

endmodule

`default_nettype wire

//--- logic/sme_state.sv
`timescale 1ns/1ps
`default_nettype none

module sme_state #(
  parameter int SMAX = 3                                    // Max hardware shares
) (
  input  wire                        g_clk,          // Global clock
  input  wire                        reset_i,        // Sync reset
  input  wire                        flush_i,        // Kill in-flight ops
  input  wire  [2:0]                 smectl_d_i,     // Shares in use
  input  wire  [1:0]                 bank_sel_i,     // Share file for bank port
  input  wire                        bank_wen_i,     // Bank write strobe
  input  wire  [sme_pkg::ADDR_W-1:0] bank_waddr_i,   // Bank write register
  input  wire  [sme_pkg::XLEN-1:0]   bank_wdata_i,   // Bank write word
  output logic [sme_pkg::XLEN-1:0]   bank_rdata_o,   // Bank read word at rs2
  input  wire                        alu_valid_i,    // Issue strobe
  input  wire  sme_pkg::sme_op_e     alu_op_i,       // Operation
  input  wire  [sme_pkg::ADDR_W-1:0] rs1_addr_i,     // Source register 1
  input  wire  [sme_pkg::ADDR_W-1:0] rs2_addr_i,     // Source register 2
  input  wire  [sme_pkg::ADDR_W-1:0] rd_addr_i,      // Destination register
  input  wire  [sme_pkg::XLEN-1:0]   rs1_share0_i,   // Share 0 of rs1 from core
  input  wire  [sme_pkg::XLEN-1:0]   rs2_share0_i,   // Share 0 of rs2 from core
  output logic                       alu_done_o,     // Result strobe
  output logic [sme_pkg::XLEN-1:0]   alu_result_o    // Share 0 of result
);

  import sme_pkg::*;

  localparam int NRAND = SMAX*(SMAX-1)/2;                   // Guard words per cycle

  // Random source
  // ----------------------------------------------------------

  logic [NRAND-1:0][XLEN-1:0] rng;                          // Fresh each cycle

  sme_rng #(
    .SMAX    (SMAX   )
  ) i_sme_rng (
    .g_clk   (g_clk  ),
    .reset_i (reset_i),
    .rng_o   (rng    )
  );

  // Operand shares
  // ----------------------------------------------------------

  wire [SMAX-1:0][XLEN-1:0] shr_rs1;                        // Share 0 from core, rest local
  wire [SMAX-1:0][XLEN-1:0] shr_rs2;

  assign shr_rs1[0] = rs1_share0_i;
  assign shr_rs2[0] = rs2_share0_i;

  // Masked ALU
  // ----------------------------------------------------------

  logic [SMAX-1:0][XLEN-1:0] alu_rd;                        // All result shares
  logic [ADDR_W-1:0]         alu_rd_addr;                   // Captured rd

  sme_alu #(
    .SMAX       (SMAX       )
  ) i_sme_alu (
    .g_clk      (g_clk      ),
    .reset_i    (reset_i    ),
    .flush_i    (flush_i    ),
    .smectl_d_i (smectl_d_i ),
    .valid_i    (alu_valid_i),
    .op_i       (alu_op_i   ),
    .rd_addr_i  (rd_addr_i  ),
    .rs1_i      (shr_rs1    ),
    .rs2_i      (shr_rs2    ),
    .rng_i      (rng        ),
    .done_o     (alu_done_o ),
    .rd_addr_o  (alu_rd_addr),
    .rd_o       (alu_rd     )
  );

  assign alu_result_o = alu_rd[0];                          // Share 0 back to core GPRs

  // Share register files
  // ----------------------------------------------------------

  // File 0 is the core GPR file, so only SMAX-1 here
  for (genvar s = 1; s < SMAX; s++) begin : g_share_rf
    logic              bank_hit;                            // Bank port targets this file
    logic              rf_wen;
    logic [ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;

    assign bank_hit = bank_wen_i && (bank_sel_i == 2'(s));
    assign rf_wen   = bank_hit || alu_done_o;               // Never both, see check
    assign rf_waddr = bank_hit ? bank_waddr_i : alu_rd_addr;
    assign rf_wdata = bank_hit ? bank_wdata_i : alu_rd[s];

    sme_regfile i_sme_regfile (
      .g_clk       (g_clk     ),
      .reset_i     (reset_i   ),
      .rs1_addr_i  (rs1_addr_i),
      .rs1_rdata_o (shr_rs1[s]),
      .rs2_addr_i  (rs2_addr_i),
      .rs2_rdata_o (shr_rs2[s]),
      .wen_i       (rf_wen    ),
      .waddr_i     (rf_waddr  ),
      .wdata_i     (rf_wdata  )
    );
  end

  // Bank read mux
  // ----------------------------------------------------------

  // Select 0 or beyond SMAX-1 reads zero
  always_comb begin
    bank_rdata_o = '0;
    for (int i = 1; i < SMAX; i++) begin
      if (bank_sel_i == 2'(i)) begin
        bank_rdata_o = shr_rs2[i];                          // Shares rs2 read port
      end
    end
  end

  // Checks
  // ----------------------------------------------------------

  // Bank writes and ALU write-back share one write port per file
  a_bank_wb_excl: assert property (
    @(posedge g_clk) disable iff (reset_i)
    !(bank_wen_i && alu_done_o)
  );

endmodule

`default_nettype wire

//--- dv/sme_state_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sme_state_tb;

  import sme_pkg::*;

  localparam int SMAX        = 3;                         // Shares built into the DUT
  localparam int N_OPS       = 16 + 20 + 6 + 2 + 3;       // Ops issued over all tests
  localparam int TIMEOUT_CYC = N_OPS * 4 + 200;

  // One in-flight operation as the compare process expects it
  typedef struct packed {
    logic [2:0]        op;
    logic [ADDR_W-1:0] rd;
    logic [XLEN-1:0]   exp;                               // Logical value of rd
    logic [31:0]       cyc;                               // Issue cycle
  } exp_t;

  // DUT signals
  // ----------------------------------------------------------

  logic              g_clk;
  logic              reset_i;
  logic              flush_i;
  logic [2:0]        smectl_d_i;
  logic [1:0]        bank_sel_i;
  logic              bank_wen_i;
  logic [ADDR_W-1:0] bank_waddr_i;
  logic [XLEN-1:0]   bank_wdata_i;
  logic [XLEN-1:0]   bank_rdata_o;
  logic              alu_valid_i;
  sme_op_e           alu_op_i;
  logic [ADDR_W-1:0] rs1_addr_i;
  logic [ADDR_W-1:0] rs2_addr_i;
  logic [ADDR_W-1:0] rd_addr_i;
  logic [XLEN-1:0]   rs1_share0_i;
  logic [XLEN-1:0]   rs2_share0_i;
  logic              alu_done_o;
  logic [XLEN-1:0]   alu_result_o;

  // Reference state
  logic [XLEN-1:0] s0 [RF_DEPTH];                         // Core GPR share 0
  logic [XLEN-1:0] lv [RF_DEPTH];                         // Logical value per register
  exp_t            exp_q [$];                             // Ops in flight in issue order
  int              ncyc     = 0;                          // Negedge count
  int              errs     = 0;
  int              checks   = 0;
  int              t_errs   = 0;
  int              t_checks = 0;
  int              n_tests  = 0;
  string           test_name = "none";
  integer          seed;

  sme_state #(
    .SMAX         (SMAX        )
  ) i_sme_state (
    .g_clk        (g_clk       ),
    .reset_i      (reset_i     ),
    .flush_i      (flush_i     ),
    .smectl_d_i   (smectl_d_i  ),
    .bank_sel_i   (bank_sel_i  ),
    .bank_wen_i   (bank_wen_i  ),
    .bank_waddr_i (bank_waddr_i),
    .bank_wdata_i (bank_wdata_i),
    .bank_rdata_o (bank_rdata_o),
    .alu_valid_i  (alu_valid_i ),
    .alu_op_i     (alu_op_i    ),
    .rs1_addr_i   (rs1_addr_i  ),
    .rs2_addr_i   (rs2_addr_i  ),
    .rd_addr_i    (rd_addr_i   ),
    .rs1_share0_i (rs1_share0_i),
    .rs2_share0_i (rs2_share0_i),
    .alu_done_o   (alu_done_o  ),
    .alu_result_o (alu_result_o)
  );

  initial g_clk = 1'b0;
  always #20 g_clk = ~g_clk;                              // 40 ns period

  // Helpers
  // ----------------------------------------------------------

  // Logical result of one op on unshared values
  function automatic logic [XLEN-1:0] ref_result(input sme_op_e op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    case (op)
      OP_XOR:  return a ^ b;
      OP_AND:  return a & b;
      OP_NOT:  return ~a;
      default: return a;                                  // Mask, unmask, remask
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    checks   = checks + 1;
    t_checks = t_checks + 1;
    if (exp !== act) begin
      errs   = errs + 1;
      t_errs = t_errs + 1;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    errs   = errs + 1;
    t_errs = t_errs + 1;
    $display("%s: %s", test_name, msg);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    t_errs    = 0;
    t_checks  = 0;
  endtask

  task automatic finish_test();
    n_tests = n_tests + 1;
    $display("%-14s %0d checks, %0d errors", test_name, t_checks, t_errs);
  endtask

  // Drives one issue cycle and queues it only when track is set
  task automatic issue_op(input sme_op_e op, input int rd, input int rs1, input int rs2,
                          input bit track);
    exp_t            e;
    logic [XLEN-1:0] a;
    @(posedge g_clk);
    a = (op == OP_MASK) ? s0[rs1] : lv[rs1];              // Mask takes the plain GPR
    alu_valid_i  <= 1'b1;
    alu_op_i     <= op;
    rd_addr_i    <= ADDR_W'(rd);
    rs1_addr_i   <= ADDR_W'(rs1);
    rs2_addr_i   <= ADDR_W'(rs2);
    rs1_share0_i <= s0[rs1];
    rs2_share0_i <= s0[rs2];
    if (track) begin
      e.op  = op;
      e.rd  = ADDR_W'(rd);
      e.exp = ref_result(op, a, lv[rs2]);
      e.cyc = 32'(ncyc + 1);                              // Negedge inside issue cycle
      exp_q.push_back(e);
    end
  endtask

  task automatic end_issue();
    @(posedge g_clk);
    alu_valid_i <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge g_clk);
  endtask

  task automatic run_op(input sme_op_e op, input int rd, input int rs1, input int rs2);
    issue_op(op, rd, rs1, rs2, 1'b1);
    end_issue();
    drain();
  endtask

  task automatic bank_read(input int sel, input int addr, output logic [XLEN-1:0] data);
    @(posedge g_clk);
    bank_sel_i <= 2'(sel);
    rs2_addr_i <= ADDR_W'(addr);
    @(negedge g_clk);
    data = bank_rdata_o;                                  // Settled mid cycle
  endtask

  task automatic bank_write(input int sel, input int addr, input logic [XLEN-1:0] data);
    @(posedge g_clk);
    bank_wen_i   <= 1'b1;
    bank_sel_i   <= 2'(sel);
    bank_waddr_i <= ADDR_W'(addr);
    bank_wdata_i <= data;
    @(posedge g_clk);
    bank_wen_i   <= 1'b0;
  endtask

  // Compare process
  // ----------------------------------------------------------

  initial begin : compare
    exp_t e;
    while (ncyc <= TIMEOUT_CYC) begin
      @(negedge g_clk);
      ncyc = ncyc + 1;
      if (alu_done_o) begin
        if (exp_q.size() == 0) begin
          note_failure("done strobe raised with no operation in flight");
        end else begin
          e = exp_q.pop_front();
          check_eq({test_name, "_latency"}, 32'd2, 32'(ncyc) - e.cyc);
          s0[e.rd] = alu_result_o;                        // Core writes share 0 back
          lv[e.rd] = e.exp;
          if (e.op == OP_UNMASK) begin
            check_eq(test_name, e.exp, alu_result_o);
          end
        end
      end else if (exp_q.size() != 0 && 32'(ncyc) > exp_q[0].cyc + 32'd2) begin
        note_failure("done strobe missing for an issued operation");
        void'(exp_q.pop_front());
      end
    end
    $display("Timeout, run stopped after %0d cycles", ncyc);
    $display("Test failed");
    $finish;
  end

  // Stimulus
  // ----------------------------------------------------------

  initial begin : main
    logic [XLEN-1:0] w1;
    logic [XLEN-1:0] w2;
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] rdata;
    sme_op_e         op;
    int              r;
    int              a;
    int              b;
    seed         = 32'hf9c1_4a15;
    reset_i      = 1'b1;
    flush_i      = 1'b0;
    smectl_d_i   = 3'd3;
    bank_sel_i   = '0;
    bank_wen_i   = 1'b0;
    bank_waddr_i = '0;
    bank_wdata_i = '0;
    alu_valid_i  = 1'b0;
    alu_op_i     = OP_XOR;
    rs1_addr_i   = '0;
    rs2_addr_i   = '0;
    rd_addr_i    = '0;
    rs1_share0_i = '0;
    rs2_share0_i = '0;
    for (int i = 0; i < RF_DEPTH; i++) begin
      s0[i] = '0;
      lv[i] = '0;                                         // Files clear on reset
    end
    repeat (3) @(posedge g_clk);
    reset_i <= 1'b0;

    start_test("reset_state");
    @(negedge g_clk);
    check_eq("reset_done", '0, XLEN'(alu_done_o));
    check_eq("reset_result", '0, alu_result_o);
    for (int s = 0; s < 4; s++) begin
      for (int ad = 0; ad < RF_DEPTH; ad++) begin
        bank_read(s, ad, rdata);
        check_eq("reset_bank", '0, rdata);
      end
    end
    finish_test();

    start_test("mask_unmask");
    for (int d = 2; d <= SMAX; d++) begin
      @(posedge g_clk);
      smectl_d_i <= 3'(d);
      for (int i = 0; i < 4; i++) begin
        s0[i] = $random(seed);                            // Plain value from core
        run_op(OP_MASK, i, i, i);
        run_op(OP_UNMASK, i, i, i);
      end
    end
    finish_test();

    start_test("bool_chain");
    for (int i = 0; i < 4; i++) begin
      s0[i] = $random(seed);
      run_op(OP_MASK, i, i, i);
    end
    for (int n = 0; n < 8; n++) begin
      r = int'($unsigned($random(seed)) % 32'd3);
      op = (r == 0) ? OP_XOR : (r == 1) ? OP_AND : OP_NOT;
      r = int'($unsigned($random(seed)) % 32'd4);
      a = int'($unsigned($random(seed)) % 32'd4);
      b = int'($unsigned($random(seed)) % 32'd4);
      run_op(op, r, a, b);
    end
    issue_op(OP_XOR, 4, 0, 1, 1'b1);
    issue_op(OP_AND, 5, 2, 3, 1'b1);                      // Two in flight
    end_issue();
    drain();
    for (int i = 0; i < 6; i++) begin
      run_op(OP_UNMASK, i, i, i);
    end
    finish_test();

    start_test("remask");
    for (int i = 10; i < 12; i++) begin
      s0[i] = $random(seed);
      run_op(OP_MASK, i, i, i);
      run_op(OP_REMASK, i, i, i);
      x = s0[i];
      for (int s = 1; s < SMAX; s++) begin
        bank_read(s, i, rdata);
        x = x ^ rdata;                                    // Recombine by hand
      end
      check_eq("remask_shares", lv[i], x);
      run_op(OP_UNMASK, i, i, i);
    end
    finish_test();

    start_test("bank_write");
    for (int i = 12; i < 14; i++) begin
      s0[i] = $random(seed);
      w1    = $random(seed);
      w2    = $random(seed);
      bank_write(1, i, w1);
      bank_write(2, i, w2);
      lv[i] = s0[i] ^ w1 ^ w2;
      run_op(OP_UNMASK, i, i, i);
    end
    finish_test();

    start_test("flush");
    s0[7] = $random(seed);
    run_op(OP_MASK, 7, 7, 7);
    issue_op(OP_XOR, 7, 7, 0, 1'b0);                      // Killed below
    @(posedge g_clk);
    alu_valid_i <= 1'b0;
    flush_i     <= 1'b1;
    @(posedge g_clk);
    flush_i     <= 1'b0;
    repeat (4) @(posedge g_clk);
    run_op(OP_UNMASK, 7, 7, 7);                           // rd must hold the mask value
    finish_test();

    repeat (4) @(posedge g_clk);                          // Catch stray done strobes
    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errs);
    if (errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
logic/sme_pkg.sv
logic/sme_rng.sv
logic/sme_regfile.sv
logic/sme_alu.sv
logic/sme_state.sv
dv/sme_state_tb.sv

//--- Makefile
# Verilator flow for the masked share block

TOP := sme_state_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

# Static checks on the whole file list
lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

# Build, run, then look for the pass line in the log
sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
